// ==== compile.f ====
ising_mem_pkg.sv
host_addr_decoder.sv
l1_bank.sv
j_port_router.sv
ising_mem_top.sv
tb_clock_gen.sv
ising_mem_assert.sv
tb_ising_mem.sv

// ==== Makefile ====
# Verilator flow for the Ising L1 memory testbench
# pass or fail is read from the simulation log

VERILATOR ?= verilator
TOP       ?= tb_ising_mem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_ising_mem.sv ====
// testbench top of the Ising L1 memory with inputs changing on the falling edge
// a model of both regions predicts each response one cycle ahead
// random data comes from a fixed seed
`timescale 1ns/100ps

module tb_ising_mem;

    localparam int JDepth    = ising_mem_pkg::J_DEPTH;
    localparam int FlipDepth = ising_mem_pkg::FLIP_DEPTH;
    localparam int JAW       = $clog2(JDepth);
    localparam int FAW       = $clog2(FlipDepth);
    localparam int DW        = ising_mem_pkg::HOST_DW;
    localparam int MapEnd    = int'(ising_mem_pkg::FLIP_BASE) + FlipDepth;
    localparam int AddrSpan  = 1 << ising_mem_pkg::HOST_AW;
    localparam int MaxCycles = 2000; // about four times the stimulus

    typedef struct packed {
        logic                   valid;
        ising_mem_pkg::j_word_t data;
    } j_exp_t;

    typedef struct packed {
        logic                      valid;
        ising_mem_pkg::flip_word_t data;
    } flip_exp_t;

    logic                      clk;
    logic                      rst_n;
    ising_mem_pkg::host_req_t  host_req;
    ising_mem_pkg::host_rsp_t  host_rsp;
    logic                      mode_sel;
    logic                      j_ren;
    logic [JAW-1:0]            j_raddr;
    ising_mem_pkg::j_word_t    j_rdata;
    logic                      j_rvalid;
    logic                      weight_ren;
    logic [JAW-1:0]            weight_raddr;
    ising_mem_pkg::j_word_t    weight;
    logic                      weight_rvalid;
    logic                      flip_ren;
    logic [FAW-1:0]            flip_raddr;
    ising_mem_pkg::flip_word_t flip_rdata;
    logic                      flip_rvalid;

    ising_mem_pkg::j_word_t    j_model    [JDepth];
    ising_mem_pkg::flip_word_t flip_model [FlipDepth];
    ising_mem_pkg::host_rsp_t  exp_host;
    j_exp_t                    exp_j;
    j_exp_t                    exp_w;
    flip_exp_t                 exp_flip;

    int host_errors   = 0;
    int j_errors      = 0;
    int weight_errors = 0;
    int flip_errors   = 0;
    int cycle_count   = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o   (clk  ),
        .rst_n_o (rst_n)
    );

    ising_mem_top #(
        .JDepth          (JDepth       ),
        .FlipDepth       (FlipDepth    )
    ) i_ising_mem_top (
        .clk_i           (clk          ),
        .rst_n_i         (rst_n        ),
        .host_req_i      (host_req     ),
        .host_rsp_o      (host_rsp     ),
        .mode_select_i   (mode_sel     ),
        .j_ren_i         (j_ren        ),
        .j_raddr_i       (j_raddr      ),
        .j_rdata_o       (j_rdata      ),
        .j_rvalid_o      (j_rvalid     ),
        .weight_ren_i    (weight_ren   ),
        .weight_raddr_i  (weight_raddr ),
        .weight_o        (weight       ),
        .weight_rvalid_o (weight_rvalid),
        .flip_ren_i      (flip_ren     ),
        .flip_raddr_i    (flip_raddr   ),
        .flip_rdata_o    (flip_rdata   ),
        .flip_rvalid_o   (flip_rvalid  )
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        int                                addr;
        logic                              in_j;
        logic                              in_flip;
        logic [ising_mem_pkg::HOST_AW-1:0] j_off;
        logic [ising_mem_pkg::HOST_AW-1:0] f_off;
        logic                              sel_en;
        logic [JAW-1:0]                    sel_addr;
        if (!rst_n) begin
            exp_host <= '0;
            exp_j    <= '0;
            exp_w    <= '0;
            exp_flip <= '0;
        end else begin
            addr    = int'(host_req.addr);
            in_j    = addr >= int'(ising_mem_pkg::J_BASE)
                      && addr < int'(ising_mem_pkg::J_BASE) + JDepth;
            in_flip = addr >= int'(ising_mem_pkg::FLIP_BASE) && addr < MapEnd;
            j_off   = host_req.addr - ising_mem_pkg::J_BASE;
            f_off   = host_req.addr - ising_mem_pkg::FLIP_BASE;

            // mapped writes give no response
            exp_host.rvalid <= host_req.valid && (!host_req.write || !(in_j || in_flip));
            exp_host.err    <= host_req.valid && !(in_j || in_flip);
            if (in_j) begin
                exp_host.rdata <= DW'(j_model[j_off[JAW-1:0]]);
            end else if (in_flip) begin
                exp_host.rdata <= DW'(flip_model[f_off[FAW-1:0]]);
            end else begin
                exp_host.rdata <= '0;
            end

            sel_en      = mode_sel ? weight_ren : j_ren;
            sel_addr    = mode_sel ? weight_raddr : j_raddr;
            exp_j.valid <= sel_en && !mode_sel;
            exp_j.data  <= j_model[sel_addr];
            exp_w.valid <= sel_en && mode_sel;
            exp_w.data  <= j_model[sel_addr];

            exp_flip.valid <= flip_ren;
            exp_flip.data  <= flip_model[flip_raddr];

            // writes come after the reads so a same-cycle read keeps the old word
            if (host_req.valid && host_req.write && in_j) begin
                j_model[j_off[JAW-1:0]] = host_req.wdata;
            end
            if (host_req.valid && host_req.write && in_flip) begin
                flip_model[f_off[FAW-1:0]] = host_req.wdata[ising_mem_pkg::NUM_SPIN-1:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response checks
    ////////////////////////////////////////////////////////////
    host_rsp_check: assert property (@(posedge clk) disable iff (!rst_n)
        exp_host.rvalid ? host_rsp == exp_host : !host_rsp.rvalid)
        else begin
            host_errors++;
            $display("mismatch host_rsp_o exp 0x%0h got 0x%0h",
                     $sampled(exp_host), $sampled(host_rsp));
        end

    j_rsp_check: assert property (@(posedge clk) disable iff (!rst_n)
        exp_j.valid ? (j_rvalid && j_rdata == exp_j.data) : !j_rvalid)
        else begin
            j_errors++;
            $display("mismatch j_rvalid_o/j_rdata_o exp 0x%0h got 0x%0h",
                     $sampled(exp_j), {$sampled(j_rvalid), $sampled(j_rdata)});
        end

    weight_rsp_check: assert property (@(posedge clk) disable iff (!rst_n)
        exp_w.valid ? (weight_rvalid && weight == exp_w.data) : !weight_rvalid)
        else begin
            weight_errors++;
            $display("mismatch weight_rvalid_o/weight_o exp 0x%0h got 0x%0h",
                     $sampled(exp_w), {$sampled(weight_rvalid), $sampled(weight)});
        end

    flip_rsp_check: assert property (@(posedge clk) disable iff (!rst_n)
        exp_flip.valid ? (flip_rvalid && flip_rdata == exp_flip.data) : !flip_rvalid)
        else begin
            flip_errors++;
            $display("mismatch flip_rvalid_o/flip_rdata_o exp 0x%0h got 0x%0h",
                     $sampled(exp_flip), {$sampled(flip_rvalid), $sampled(flip_rdata)});
        end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic clear_inputs();
        host_req     = '0;
        mode_sel     = 1'b0;
        j_ren        = 1'b0;
        j_raddr      = '0;
        weight_ren   = 1'b0;
        weight_raddr = '0;
        flip_ren     = 1'b0;
        flip_raddr   = '0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic host_access(input logic wr, input int addr, input logic [DW-1:0] data);
        @(negedge clk);
        clear_inputs();
        host_req.valid = 1'b1;
        host_req.write = wr;
        host_req.addr  = addr[ising_mem_pkg::HOST_AW-1:0];
        host_req.wdata = data;
    endtask

    // both requesters ask and the idle one reads a random row
    task automatic j_read(input logic mode, input int addr);
        logic [31:0] rnd;
        rnd = $urandom;
        @(negedge clk);
        clear_inputs();
        mode_sel     = mode;
        j_ren        = 1'b1;
        weight_ren   = 1'b1;
        j_raddr      = mode ? rnd[JAW-1:0] : addr[JAW-1:0];
        weight_raddr = mode ? addr[JAW-1:0] : rnd[JAW-1:0];
    endtask

    task automatic flip_read(input int addr);
        @(negedge clk);
        clear_inputs();
        flip_ren   = 1'b1;
        flip_raddr = addr[FAW-1:0];
    endtask

    task automatic random_cycle();
        logic [31:0] rnd;
        rnd = $urandom;
        @(negedge clk);
        clear_inputs();
        host_req.valid = rnd[0];
        host_req.write = rnd[1];
        host_req.addr  = {1'b0, rnd[6:2]}; // a quarter of these are unmapped
        host_req.wdata = {$urandom, $urandom};
        mode_sel       = rnd[7];
        j_ren          = rnd[8];
        j_raddr        = rnd[9 +: JAW];
        weight_ren     = rnd[14];
        weight_raddr   = rnd[15 +: JAW];
        flip_ren       = rnd[20];
        flip_raddr     = rnd[21 +: FAW];
    endtask

    task automatic finish_run(input logic timed_out);
        int protocol_errors;
        int total;
        protocol_errors = i_ising_mem_top.i_ising_mem_assert.fail_count;
        total = host_errors + j_errors + weight_errors + flip_errors + protocol_errors;
        $display("errors: host %0d, j %0d, weight %0d, flip %0d, protocol %0d, timeout %0d",
                 host_errors, j_errors, weight_errors, flip_errors, protocol_errors,
                 timed_out);
        if (total == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MaxCycles) begin
            $display("timeout: run did not finish within %0d cycles", MaxCycles);
            finish_run(1'b1);
        end
    end

    initial begin
        clear_inputs();
        void'($urandom(63));
        @(posedge rst_n);
        idle(3);
        for (int a = 0; a < MapEnd; a++) begin
            host_access(1'b1, a, {$urandom, $urandom});
        end
        for (int a = 0; a < MapEnd; a++) begin
            host_access(1'b0, a, '0);
        end
        // unmapped accesses followed by a readback of the whole map
        for (int a = MapEnd; a < AddrSpan; a += 13) begin
            host_access(1'b1, a, {$urandom, $urandom});
            host_access(1'b0, a, '0);
        end
        for (int a = 0; a < MapEnd; a++) begin
            host_access(1'b0, a, '0);
        end
        for (int m = 0; m < 2; m++) begin
            for (int a = 0; a < JDepth; a++) begin
                j_read(m[0], a);
            end
        end
        for (int i = 0; i < 64; i++) begin
            j_read(i[0], i % JDepth); // mode flips with a read in flight
        end
        for (int a = 0; a < FlipDepth; a++) begin
            flip_read(a);
        end
        for (int a = 0; a < FlipDepth; a++) begin
            host_access(1'b1, int'(ising_mem_pkg::FLIP_BASE) + a, {$urandom, $urandom});
            flip_ren   = 1'b1;
            flip_raddr = a[FAW-1:0];
        end
        for (int a = 0; a < FlipDepth; a++) begin
            flip_read(a);
        end
        repeat (300) random_cycle();
        idle(4);
        finish_run(1'b0);
    end

endmodule

// ==== ising_mem_assert.sv ====
// protocol checks bound to the ports of ising_mem_top
// checks valid timing and exclusivity but no data values
`timescale 1ns/100ps

module ising_mem_assert #(
    parameter int FlipDepth = ising_mem_pkg::FLIP_DEPTH
) (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input ising_mem_pkg::host_req_t host_req_i,
    input ising_mem_pkg::host_rsp_t host_rsp_o,
    input logic                     mode_select_i,
    input logic                     j_ren_i,
    input logic                     weight_ren_i,
    input logic                     j_rvalid_o,
    input logic                     weight_rvalid_o,
    input logic                     flip_ren_i,
    input logic                     flip_rvalid_o
);

    localparam int MapEnd = int'(ising_mem_pkg::FLIP_BASE) + FlipDepth;

    int fail_count = 0; // number of failed checks

    // host side
    host_read_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        host_req_i.valid && !host_req_i.write |=> host_rsp_o.rvalid)
        else begin
            fail_count++;
            $error("host read got no response one cycle later");
        end
    host_unmapped_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        host_req_i.valid && int'(host_req_i.addr) >= MapEnd |=> host_rsp_o.rvalid && host_rsp_o.err)
        else begin
            fail_count++;
            $error("unmapped host access got no error response one cycle later");
        end
    host_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        host_rsp_o.rvalid |-> $past(host_req_i.valid))
        else begin
            fail_count++;
            $error("host response without a request in the cycle before");
        end

    // J direct port where the served requester depends on the mode
    j_read_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mode_select_i ? weight_ren_i : j_ren_i) |=> j_rvalid_o || weight_rvalid_o)
        else begin
            fail_count++;
            $error("J direct read got no result one cycle later");
        end
    j_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        j_rvalid_o |-> $past(j_ren_i && !mode_select_i))
        else begin
            fail_count++;
            $error("load result without a load read in mode 0 the cycle before");
        end
    weight_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        weight_rvalid_o |-> $past(weight_ren_i && mode_select_i))
        else begin
            fail_count++;
            $error("weight result without a compute read in mode 1 the cycle before");
        end
    one_requester: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(j_rvalid_o && weight_rvalid_o))
        else begin
            fail_count++;
            $error("load and compute results valid in the same cycle");
        end

    // flip direct port
    flip_read_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flip_ren_i |=> flip_rvalid_o)
        else begin
            fail_count++;
            $error("flip read got no result one cycle later");
        end
    flip_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flip_rvalid_o |-> $past(flip_ren_i))
        else begin
            fail_count++;
            $error("flip result without a flip read the cycle before");
        end

    // checked while reset is held
    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !(host_rsp_o.rvalid || j_rvalid_o || weight_rvalid_o || flip_rvalid_o))
        else begin
            fail_count++;
            $error("output valid high during reset");
        end

endmodule

bind ising_mem_top ising_mem_assert #(
    .FlipDepth       (FlipDepth      )
) i_ising_mem_assert (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .host_req_i      (host_req_i     ),
    .host_rsp_o      (host_rsp_o     ),
    .mode_select_i   (mode_select_i  ),
    .j_ren_i         (j_ren_i        ),
    .weight_ren_i    (weight_ren_i   ),
    .j_rvalid_o      (j_rvalid_o     ),
    .weight_rvalid_o (weight_rvalid_o),
    .flip_ren_i      (flip_ren_i     ),
    .flip_rvalid_o   (flip_rvalid_o  )
);

// ==== tb_clock_gen.sv ====
// clock and reset source for the testbench, 20 ns period
// reset falls at 1 ns and is released on a falling edge after 4 rising edges
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HalfPeriod  = 10,
    parameter int ResetCycles = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HalfPeriod) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0; // real falling edge, flops clear before the first clock
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== ising_mem_top.sv ====
// L1 memory side of the Ising core, host bus plus direct J and flip ports
// every path has one cycle latency, JDepth must not exceed FLIP_BASE
`timescale 1ns/100ps

module ising_mem_top #(
    parameter int JDepth    = ising_mem_pkg::J_DEPTH,
    parameter int FlipDepth = ising_mem_pkg::FLIP_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // host bus
    input  ising_mem_pkg::host_req_t     host_req_i,
    output ising_mem_pkg::host_rsp_t     host_rsp_o,

    // J direct port, requester picked by mode
    input  logic                         mode_select_i,
    input  logic                         j_ren_i,
    input  logic [$clog2(JDepth)-1:0]    j_raddr_i,
    output ising_mem_pkg::j_word_t       j_rdata_o,
    output logic                         j_rvalid_o,
    input  logic                         weight_ren_i,
    input  logic [$clog2(JDepth)-1:0]    weight_raddr_i,
    output ising_mem_pkg::j_word_t       weight_o,
    output logic                         weight_rvalid_o,

    // flip direct port
    input  logic                         flip_ren_i,
    input  logic [$clog2(FlipDepth)-1:0] flip_raddr_i,
    output ising_mem_pkg::flip_word_t    flip_rdata_o,
    output logic                         flip_rvalid_o
);

    ising_mem_pkg::bank_req_t    j_req;
    ising_mem_pkg::bank_req_t    flip_req;
    ising_mem_pkg::j_word_t      j_host_rdata;
    ising_mem_pkg::flip_word_t   flip_host_rdata;
    logic                        j_bank_en;
    logic [$clog2(JDepth)-1:0]   j_bank_addr;
    ising_mem_pkg::j_word_t      j_bank_data;

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////
    host_addr_decoder #(
        .JDepth       (JDepth         ),
        .FlipDepth    (FlipDepth      )
    ) i_host_addr_decoder (
        .clk_i        (clk_i          ),
        .rst_n_i      (rst_n_i        ),
        .host_req_i   (host_req_i     ),
        .j_req_o      (j_req          ),
        .flip_req_o   (flip_req       ),
        .j_rdata_i    (j_host_rdata   ),
        .flip_rdata_i (flip_host_rdata),
        .host_rsp_o   (host_rsp_o     )
    );

    ////////////////////////////////////////////////////////////
    // banks
    ////////////////////////////////////////////////////////////
    l1_bank #(
        .word_t       (ising_mem_pkg::j_word_t),
        .Depth        (JDepth         )
    ) i_l1_j (
        .clk_i        (clk_i          ),
        .host_req_i   (j_req          ),
        .host_rdata_o (j_host_rdata   ),
        .rd_en_i      (j_bank_en      ),
        .rd_addr_i    (j_bank_addr    ),
        .rd_data_o    (j_bank_data    )
    );

    l1_bank #(
        .word_t       (ising_mem_pkg::flip_word_t),
        .Depth        (FlipDepth      )
    ) i_l1_flip (
        .clk_i        (clk_i          ),
        .host_req_i   (flip_req       ),
        .host_rdata_o (flip_host_rdata),
        .rd_en_i      (flip_ren_i     ),
        .rd_addr_i    (flip_raddr_i   ),
        .rd_data_o    (flip_rdata_o   )
    );

    // flip reads have a single requester, so one flop carries the valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flip_rvalid_o <= 1'b0;
        end else begin
            flip_rvalid_o <= flip_ren_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // J port sharing
    ////////////////////////////////////////////////////////////
    j_port_router #(
        .JDepth          (JDepth         )
    ) i_j_port_router (
        .clk_i           (clk_i          ),
        .rst_n_i         (rst_n_i        ),
        .mode_select_i   (mode_select_i  ),
        .j_ren_i         (j_ren_i        ),
        .j_raddr_i       (j_raddr_i      ),
        .weight_ren_i    (weight_ren_i   ),
        .weight_raddr_i  (weight_raddr_i ),
        .bank_en_o       (j_bank_en      ),
        .bank_addr_o     (j_bank_addr    ),
        .bank_data_i     (j_bank_data    ),
        .j_rdata_o       (j_rdata_o      ),
        .j_rvalid_o      (j_rvalid_o     ),
        .weight_o        (weight_o       ),
        .weight_rvalid_o (weight_rvalid_o)
    );

endmodule

// ==== j_port_router.sv ====
// shares the J direct port between load (mode 0) and compute (mode 1)
// results follow the mode of their request cycle, one read in flight per cycle
`timescale 1ns/100ps

module j_port_router #(
    parameter int JDepth = ising_mem_pkg::J_DEPTH
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      mode_select_i, // 0 load, 1 compute

    // load requester
    input  logic                      j_ren_i,
    input  logic [$clog2(JDepth)-1:0] j_raddr_i,

    // compute requester
    input  logic                      weight_ren_i,
    input  logic [$clog2(JDepth)-1:0] weight_raddr_i,

    // J bank direct port
    output logic                      bank_en_o,
    output logic [$clog2(JDepth)-1:0] bank_addr_o,
    input  ising_mem_pkg::j_word_t    bank_data_i,

    // results
    output ising_mem_pkg::j_word_t    j_rdata_o,
    output logic                      j_rvalid_o,
    output ising_mem_pkg::j_word_t    weight_o,
    output logic                      weight_rvalid_o
);

    typedef struct packed {
        logic load;
        logic compute;
    } route_t;

    route_t route_d;
    route_t route_q;

    ////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (mode_select_i) begin
            bank_en_o   = weight_ren_i;
            bank_addr_o = weight_raddr_i;
        end else begin
            bank_en_o   = j_ren_i;
            bank_addr_o = j_raddr_i;
        end
    end

    // remember who asked, the mode may flip before the data is back
    assign route_d.load    = bank_en_o & !mode_select_i;
    assign route_d.compute = bank_en_o & mode_select_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            route_q <= '0;
        end else begin
            route_q <= route_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // result steering
    ////////////////////////////////////////////////////////////
    assign j_rvalid_o      = route_q.load;
    assign weight_rvalid_o = route_q.compute;
    assign j_rdata_o       = route_q.load    ? bank_data_i : '0;
    assign weight_o        = route_q.compute ? bank_data_i : '0; // idle requester sees zero

endmodule

// ==== l1_bank.sv ====
// single clock bank, host read/write port plus one direct read port
// direct read sees the old word on a same-cycle host write, contents not reset
`timescale 1ns/100ps

module l1_bank #(
    parameter type word_t = logic [63:0],
    parameter int  Depth  = 16
) (
    input  logic                     clk_i,

    // host side
    input  ising_mem_pkg::bank_req_t host_req_i,
    output word_t                    host_rdata_o,

    // direct read side
    input  logic                     rd_en_i,
    input  logic [$clog2(Depth)-1:0] rd_addr_i,
    output word_t                    rd_data_o
);

    localparam int AW = $clog2(Depth);
    localparam int WW = $bits(word_t);

    word_t           mem_q [Depth];
    logic [AW-1:0]   host_addr;
    word_t           host_wdata;
    logic            host_we;
    logic            host_re;

    ////////////////////////////////////////////////////////////
    // host port
    ////////////////////////////////////////////////////////////
    // the decoder only passes addresses inside the region
    assign host_addr  = host_req_i.addr[AW-1:0];
    assign host_wdata = host_req_i.wdata[WW-1:0]; // drop bits above the word
    assign host_we    = host_req_i.valid & host_req_i.write;
    assign host_re    = host_req_i.valid & !host_req_i.write;

    always_ff @(posedge clk_i) begin
        if (host_we) begin
            mem_q[host_addr] <= host_wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (host_re) begin
            host_rdata_o <= mem_q[host_addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // direct read port
    ////////////////////////////////////////////////////////////
    // nonblocking write above gives read-before-write on a collision
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

// ==== host_addr_decoder.sv ====
// routes host requests to the J or flip bank, no back-pressure
// mapped writes give no response, unmapped accesses answer with err one cycle later
`timescale 1ns/100ps

module host_addr_decoder #(
    parameter int JDepth    = ising_mem_pkg::J_DEPTH,
    parameter int FlipDepth = ising_mem_pkg::FLIP_DEPTH
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  ising_mem_pkg::host_req_t  host_req_i,
    output ising_mem_pkg::bank_req_t  j_req_o,
    output ising_mem_pkg::bank_req_t  flip_req_o,
    input  ising_mem_pkg::j_word_t    j_rdata_i,
    input  ising_mem_pkg::flip_word_t flip_rdata_i,
    output ising_mem_pkg::host_rsp_t  host_rsp_o
);

    // one extra bit so region ends never wrap
    typedef logic [ising_mem_pkg::HOST_AW:0] addr_ext_t;

    typedef struct packed {
        logic rvalid;
        logic err;
        logic from_flip;
    } rsp_state_t;

    localparam addr_ext_t JLo    = addr_ext_t'(ising_mem_pkg::J_BASE);
    localparam addr_ext_t JHi    = JLo + addr_ext_t'(JDepth);
    localparam addr_ext_t FlipLo = addr_ext_t'(ising_mem_pkg::FLIP_BASE);
    localparam addr_ext_t FlipHi = FlipLo + addr_ext_t'(FlipDepth);

    addr_ext_t  addr_ext;
    logic       hit_j;
    logic       hit_flip;
    logic       unmapped;
    rsp_state_t rsp_d;
    rsp_state_t rsp_q;

    ////////////////////////////////////////////////////////////
    // region decode
    ////////////////////////////////////////////////////////////
    assign addr_ext = addr_ext_t'(host_req_i.addr);
    assign hit_j    = (addr_ext >= JLo) && (addr_ext < JHi);
    assign hit_flip = !hit_j && (addr_ext >= FlipLo) && (addr_ext < FlipHi);
    assign unmapped = !hit_j && !hit_flip;

    always_comb begin
        j_req_o.valid = host_req_i.valid & hit_j;
        j_req_o.write = host_req_i.write;
        j_req_o.addr  = host_req_i.addr - ising_mem_pkg::J_BASE; // local word index
        j_req_o.wdata = host_req_i.wdata;

        flip_req_o.valid = host_req_i.valid & hit_flip;
        flip_req_o.write = host_req_i.write;
        flip_req_o.addr  = host_req_i.addr - ising_mem_pkg::FLIP_BASE;
        flip_req_o.wdata = host_req_i.wdata;
    end

    ////////////////////////////////////////////////////////////
    // response tracking
    ////////////////////////////////////////////////////////////
    always_comb begin
        rsp_d.rvalid    = host_req_i.valid & (!host_req_i.write | unmapped);
        rsp_d.err       = host_req_i.valid & unmapped;
        rsp_d.from_flip = hit_flip; // picks the bank whose data comes back
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= rsp_d;
        end
    end

    // bank data is already registered, so only the mux sits here
    always_comb begin
        host_rsp_o.rvalid = rsp_q.rvalid;
        host_rsp_o.err    = rsp_q.err;
        if (rsp_q.err) begin
            host_rsp_o.rdata = '0;
        end else if (rsp_q.from_flip) begin
            host_rsp_o.rdata = {{(ising_mem_pkg::HOST_DW - ising_mem_pkg::NUM_SPIN){1'b0}},
                                flip_rdata_i};
        end else begin
            host_rsp_o.rdata = j_rdata_i;
        end
    end

endmodule

// ==== ising_mem_pkg.sv ====
// shared sizes, word types and host bus structs of the Ising L1 memory
// word addresses only, the J region must fit below FLIP_BASE
package ising_mem_pkg;

    ////////////////////////////////////////////////////////////
    // core sizes
    ////////////////////////////////////////////////////////////
    localparam int NUM_SPIN   = 16;
    localparam int BIT_J      = 4;  // bits per coupling weight
    localparam int J_DEPTH    = 16; // one row per spin
    localparam int FLIP_DEPTH = 8;

    // host bus
    localparam int HOST_AW = 6;  // word address
    localparam int HOST_DW = 64;

    ////////////////////////////////////////////////////////////
    // word types
    ////////////////////////////////////////////////////////////
    // one J row holds the weights of a spin towards all others
    typedef logic [NUM_SPIN*BIT_J-1:0] j_word_t;
    typedef logic [NUM_SPIN-1:0]       flip_word_t;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    localparam logic [HOST_AW-1:0] J_BASE    = 6'd0;
    localparam logic [HOST_AW-1:0] FLIP_BASE = 6'd16;
    // map ends at FLIP_BASE + FLIP_DEPTH, anything above is unmapped

    ////////////////////////////////////////////////////////////
    // bus structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic               valid;
        logic               write;
        logic [HOST_AW-1:0] addr;
        logic [HOST_DW-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic               rvalid;
        logic               err;   // unmapped access
        logic [HOST_DW-1:0] rdata;
    } host_rsp_t;

    // host port of a bank, addr is local to the region
    typedef struct packed {
        logic               valid;
        logic               write;
        logic [HOST_AW-1:0] addr;
        logic [HOST_DW-1:0] wdata; // bank keeps only the low bits
    } bank_req_t;

endpackage
